/* bench/ppu_mem_model.sv */
`timescale 1ns/1ps

// Tile map, tile graphics and palette memories with one cycle of read latency
module ppu_mem_model
    import ppu_pkg::*;
(
    input  logic      clk,
    input  map_addr_t addr_tile_map,
    input  gfx_addr_t addr_tile_gfx,
    input  pal_addr_t addr_palette,
    output map_word_t read_data_tile_map,
    output gfx_word_t read_data_tile_gfx,
    output rgb_t      read_data_palette
);

    // Filled by the testbench through hierarchical references
    map_word_t map_mem [2**$bits(map_addr_t)];
    gfx_word_t gfx_mem [2**$bits(gfx_addr_t)];
    rgb_t      pal_mem [2**$bits(pal_addr_t)];

    initial begin
        read_data_tile_map <= '0;
        read_data_tile_gfx <= '0;
        read_data_palette  <= '0;
    end

    // Data for an address shows up on the next edge
    always @(posedge clk) begin
        read_data_tile_map <= map_mem[addr_tile_map];
        read_data_tile_gfx <= gfx_mem[addr_tile_gfx];
        read_data_palette  <= pal_mem[addr_palette];
    end

endmodule

/* bench/tb_ppu.sv */
`timescale 1ns/1ps

module tb_ppu
    import ppu_pkg::*;
();

    localparam int line_hcounts = tiles_per_line * 2 * tile_px;  // Two hcounts per pixel

    logic      clk = 1'b0;
    logic      reset;
    hcount_t   hcount;
    vcount_t   vcount;
    logic      vblank;
    logic      hsync;
    map_addr_t addr_tile_map;
    gfx_addr_t addr_tile_gfx;
    pal_addr_t addr_palette;
    map_word_t read_data_tile_map;
    gfx_word_t read_data_tile_gfx;
    rgb_t      read_data_palette;
    rgb_t      pixel_color;
    int        value_errors = 0;
    int        timeouts = 0;

    always #5 clk = ~clk;

    ppu_top u_dut (.*);
    ppu_mem_model u_mem (.*);

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t want);
        if (got !== want) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_map_addr(input string name, input map_addr_t got, input map_addr_t want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_gfx_addr(input string name, input gfx_addr_t got, input gfx_addr_t want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_pal_addr(input string name, input pal_addr_t got, input pal_addr_t want);
        if (got !== want) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic fill_palette();
        for (int i = 0; i < palette_entries; i++) begin
            u_mem.pal_mem[i] = 24'($urandom);
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 2**$bits(map_addr_t); i++) begin
            u_mem.map_mem[i] = map_word_t'($urandom);
        end
        for (int i = 0; i < 2**$bits(gfx_addr_t); i++) begin
            u_mem.gfx_mem[i] = gfx_word_t'($urandom);
        end
        fill_palette();
    endtask

    // Tile map entry of one tile position on a line, taken from the memory contents
    function automatic map_entry_t tile_entry(input int tile, input int v);
        map_word_t word;
        word = u_mem.map_mem[(v / tile_px) * map_words_per_row + tile / tiles_per_word];
        return map_entry_t'(word[8 * (tile % tiles_per_word) +: 8]);
    endfunction

    // Colour for one hcount, worked out from the memory contents
    function automatic rgb_t expected_color(input int h, input int v);
        map_entry_t entry;
        gfx_word_t  row;
        int         tile;
        int         pixel;
        logic [1:0] value;
        tile  = h / (2 * tile_px);
        pixel = (h / 2) % tile_px;  // Both hcounts of a pixel give the same colour
        entry = tile_entry(tile, v);
        row   = u_mem.gfx_mem[entry.tile_id * tile_px + v % tile_px];
        value = row[31 - 2 * pixel -: 2];
        return u_mem.pal_mem[colors_per_palette * entry.pal_sel + value];
    endfunction

    task automatic check_after_reset();
        @(negedge clk);
        check_rgb("pixel_color", pixel_color, '0);
        check_map_addr("addr_tile_map", addr_tile_map, '0);
        check_gfx_addr("addr_tile_gfx", addr_tile_gfx, '0);
        check_pal_addr("addr_palette", addr_palette, '0);
    endtask

    task automatic check_palette_load();
        @(posedge clk);
        vblank <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_pal_addr("addr_palette", addr_palette, pal_addr_t'(i < palette_entries ? i : 0));
        end
        @(posedge clk);
        vblank <= 1'b0;
    endtask

    task automatic load_palette();
        int n = 0;
        @(posedge clk);
        vblank <= 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (addr_palette != 3'd7 && n < 20);
        if (addr_palette != 3'd7) begin
            $display("Timeout waiting for the palette load to reach entry 7");
            timeouts++;
        end
        repeat (2) @(posedge clk);  // Last entry lands in the table
        vblank <= 1'b0;
    endtask

    task automatic fetch_line(input int v);
        map_addr_t  want_map;
        gfx_addr_t  want_gfx;
        map_entry_t entry;
        @(posedge clk);
        vcount <= vcount_t'(v);
        hsync  <= 1'b1;
        for (int t = 0; t < 50; t++) begin
            @(negedge clk);
            want_map = '0;
            want_gfx = '0;
            if (t < tiles_per_line) begin
                want_map = map_addr_t'((v / tile_px) * map_words_per_row + t / tiles_per_word);
            end
            // Graphics address trails the map address by one cycle
            if (t >= 1 && t <= tiles_per_line) begin
                entry    = tile_entry(t - 1, v);
                want_gfx = gfx_addr_t'(entry.tile_id * tile_px + v % tile_px);
            end
            check_map_addr("addr_tile_map", addr_tile_map, want_map);
            check_gfx_addr("addr_tile_gfx", addr_tile_gfx, want_gfx);
        end
        @(posedge clk);
        hsync <= 1'b0;
    endtask

    // pixel_color trails hcount by one cycle
    task automatic sweep_line(input int v);
        for (int i = 0; i <= line_hcounts; i++) begin
            @(posedge clk);
            if (i < line_hcounts) begin
                hcount <= hcount_t'(i);
            end
            @(negedge clk);
            if (i > 0) begin
                check_rgb("pixel_color", pixel_color, expected_color(i - 1, v));
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb9adfccf));
        reset  <= 1'b1;
        hcount <= '0;
        vcount <= '0;
        vblank <= 1'b0;
        hsync  <= 1'b0;
        fill_memories();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_after_reset();
        check_palette_load();
        fetch_line(37);       // Tile row 2, line 5
        sweep_line(37);
        fetch_line(203);      // Tile row 12, line 11
        sweep_line(203);
        fill_palette();
        load_palette();
        sweep_line(203);

        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* hdl/line_table.sv */
`timescale 1ns/1ps

// Register-file table with one write port and a combinational read port
module line_table #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write_en,
    input  logic [$clog2(depth)-1:0] write_index,
    input  entry_t                   write_data,
    input  logic [$clog2(depth)-1:0] read_index,
    output entry_t                   read_data
);

    entry_t entries [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= '0;
            end
        end else if (write_en) begin
            entries[write_index] <= write_data;
        end
    end

    assign read_data = entries[read_index];

    // Both the loader side and the reader side must stay inside the table
    assert property (@(posedge clk) disable iff (reset) write_en |-> write_index < depth)
        else $error("line_table: write index %0d out of range", write_index);
    assert property (@(posedge clk) disable iff (reset) read_index < depth)
        else $error("line_table: read index %0d out of range", read_index);

endmodule

/* hdl/palette_loader.sv */
`timescale 1ns/1ps

// Loads the colour palette at the start of vblank and serves colour lookups
module palette_loader
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      vblank,
    output pal_addr_t addr_palette,
    input  rgb_t      read_data_palette,
    input  pal_idx_t  lookup_index,
    output rgb_t      lookup_color
);

    logic [$clog2(palette_entries + 1)-1:0] load_count;
    logic      issue;
    logic      write_en;     // Data for write_index arrives this cycle
    pal_addr_t write_index;

    assign issue = vblank && load_count < palette_entries;

    // Address tracks the counter, idles at 0
    assign addr_palette = issue ? pal_addr_t'(load_count) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_count <= '0;
            write_en   <= 1'b0;
        end else begin
            write_en <= issue;
            if (!vblank) begin
                load_count <= '0;  // Re-arm for the next frame
            end else if (issue) begin
                load_count <= load_count + 1'b1;
            end
        end
    end

    // Delayed copy of the address, lines up with the memory latency
    always_ff @(posedge clk) begin
        write_index <= addr_palette;
    end

    line_table #(
        .entry_t (rgb_t),
        .depth   (palette_entries)
    ) u_table (
        .clk         (clk),
        .reset       (reset),
        .write_en    (write_en),
        .write_index (write_index),
        .write_data  (read_data_palette),
        .read_index  (lookup_index),
        .read_data   (lookup_color)
    );

endmodule

/* hdl/pixel_output.sv */
`timescale 1ns/1ps

// Turns hcount into a background colour during active video
module pixel_output
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       vblank,
    input  logic       hsync,
    input  hcount_t    hcount,
    output tile_idx_t  read_tile,
    input  tile_line_t read_line,
    output pal_idx_t   lookup_index,
    input  rgb_t       lookup_color,
    output rgb_t       pixel_color
);

    pixel_idx_t pixel;
    logic [1:0] pixel_value;

    // Top bits pick the tile
    assign read_tile = hcount[$bits(hcount_t)-1 -: $bits(tile_idx_t)];

    // Bit 0 is dropped, each pixel is shown for two hcount values
    assign pixel = hcount[$bits(pixel_idx_t):1];

    // Pixel 0 lives in the top two bits of the row word
    assign pixel_value = read_line.gfx[$bits(gfx_word_t) - 1 - 2 * pixel -: 2];

    assign lookup_index = pal_idx_t'(colors_per_palette * read_line.pal_sel + pixel_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (!vblank && !hsync) begin
            pixel_color <= lookup_color;  // Held through blanking
        end
    end

endmodule

/* hdl/ppu_pkg.sv */
package ppu_pkg;

    // Background geometry
    localparam int tile_px            = 16;  // Pixels per tile edge
    localparam int tiles_per_line     = 40;
    localparam int tiles_per_word     = 4;   // Tile map entries per 32-bit word
    localparam int map_words_per_row  = 10;
    localparam int tile_rows          = 30;  // Visible tile rows in a frame

    // Palette layout
    localparam int palette_entries    = 8;
    localparam int colors_per_palette = 4;

    // Line fetch needs 40 tiles plus two cycles of pipeline drain
    localparam int fetch_cycles       = 42;

    // Video timing counts
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // Memory addresses
    typedef logic [8:0]  map_addr_t;
    typedef logic [10:0] gfx_addr_t;
    typedef logic [2:0]  pal_addr_t;

    // Memory words
    typedef logic [31:0] map_word_t;
    typedef logic [31:0] gfx_word_t;

    typedef logic [5:0]  tile_idx_t;   // Tile position on a line
    typedef logic [3:0]  pixel_idx_t;  // Pixel inside a tile
    typedef logic [2:0]  pal_idx_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // One byte of a tile map word
    typedef struct packed {
        logic       pal_sel;
        logic [6:0] tile_id;
    } map_entry_t;

    // One background tile as held for the current line
    typedef struct packed {
        logic      pal_sel;
        gfx_word_t gfx;
    } tile_line_t;

endpackage

/* hdl/ppu_top.sv */
`timescale 1ns/1ps

// Background path of the picture processing unit
module ppu_top
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Video timing
    input  hcount_t   hcount,
    input  vcount_t   vcount,
    input  logic      vblank,
    input  logic      hsync,

    // Memory ports, data returns one cycle after the address
    output map_addr_t addr_tile_map,
    output gfx_addr_t addr_tile_gfx,
    output pal_addr_t addr_palette,
    input  map_word_t read_data_tile_map,
    input  gfx_word_t read_data_tile_gfx,
    input  rgb_t      read_data_palette,

    output rgb_t      pixel_color
);

    pal_idx_t   lookup_index;
    rgb_t       lookup_color;
    tile_idx_t  read_tile;
    tile_line_t read_line;

    palette_loader u_palette (
        .clk               (clk),
        .reset             (reset),
        .vblank            (vblank),
        .addr_palette      (addr_palette),
        .read_data_palette (read_data_palette),
        .lookup_index      (lookup_index),
        .lookup_color      (lookup_color)
    );

    tile_fetcher u_fetch (
        .clk                (clk),
        .reset              (reset),
        .hsync              (hsync),
        .vblank             (vblank),
        .vcount             (vcount),
        .addr_tile_map      (addr_tile_map),
        .read_data_tile_map (read_data_tile_map),
        .addr_tile_gfx      (addr_tile_gfx),
        .read_data_tile_gfx (read_data_tile_gfx),
        .read_tile          (read_tile),
        .read_line          (read_line)
    );

    pixel_output u_pixel (
        .clk          (clk),
        .reset        (reset),
        .vblank       (vblank),
        .hsync        (hsync),
        .hcount       (hcount),
        .read_tile    (read_tile),
        .read_line    (read_line),
        .lookup_index (lookup_index),
        .lookup_color (lookup_color),
        .pixel_color  (pixel_color)
    );

endmodule

/* hdl/tile_fetcher.sv */
`timescale 1ns/1ps

// Fetches the 40 background tiles of the current line during hsync
module tile_fetcher
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       hsync,
    input  logic       vblank,
    input  vcount_t    vcount,
    output map_addr_t  addr_tile_map,
    input  map_word_t  read_data_tile_map,
    output gfx_addr_t  addr_tile_gfx,
    input  gfx_word_t  read_data_tile_gfx,
    input  tile_idx_t  read_tile,
    output tile_line_t read_line
);

    logic [$clog2(fetch_cycles + 1)-1:0] tile_count;
    logic       active;
    logic       s1_valid;
    logic       s2_valid;
    tile_idx_t  s2_tile;
    logic       s3_valid;
    tile_idx_t  s3_tile;
    logic       s3_pal;
    map_entry_t map_entry;
    tile_line_t line_entry;

    assign active   = hsync && !vblank;  // vblank wins over hsync
    assign s1_valid = active && tile_count < tiles_per_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_count <= '0;
        end else if (!active) begin
            tile_count <= '0;
        end else if (tile_count < fetch_cycles) begin
            tile_count <= tile_count + 1'b1;  // Saturates once the line is done
        end
    end

    // Stage 1: tile map word holding this tile
    assign addr_tile_map = s1_valid
        ? map_addr_t'((vcount / tile_px) * map_words_per_row + tile_count / tiles_per_word)
        : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // Tile position and palette bit ride along with the valids
    always_ff @(posedge clk) begin
        s2_tile <= tile_idx_t'(tile_count);
        s3_tile <= s2_tile;
        s3_pal  <= map_entry.pal_sel;
    end

    // Stage 2: entry k of a map word sits in byte k
    assign map_entry = map_entry_t'(
        read_data_tile_map[(s2_tile % tiles_per_word) * $bits(map_entry_t) +: $bits(map_entry_t)]);

    // Row of the tile graphics for the line inside the tile
    assign addr_tile_gfx = s2_valid
        ? gfx_addr_t'(map_entry.tile_id * tile_px + vcount % tile_px)
        : '0;

    // Stage 3: graphics word joins the palette bit in the line table
    assign line_entry = tile_line_t'{pal_sel: s3_pal, gfx: read_data_tile_gfx};

    line_table #(
        .entry_t (tile_line_t),
        .depth   (tiles_per_line)
    ) u_line (
        .clk         (clk),
        .reset       (reset),
        .write_en    (s3_valid),
        .write_index (s3_tile),
        .write_data  (line_entry),
        .read_index  (read_tile),
        .read_data   (read_line)
    );

    // vcount from the video timing must stay inside the visible tile rows
    assert property (@(posedge clk) disable iff (reset)
        hsync |-> addr_tile_map < map_addr_t'(tile_rows * map_words_per_row))
        else $error("tile_fetcher: map address %0d beyond last tile row", addr_tile_map);

endmodule

/* ppu_top.f */
hdl/ppu_pkg.sv
hdl/line_table.sv
hdl/palette_loader.sv
hdl/tile_fetcher.sv
hdl/pixel_output.sv
hdl/ppu_top.sv
bench/ppu_mem_model.sv
bench/tb_ppu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ppu -f ppu_top.f -o tb_ppu
out=$(./obj_dir/tb_ppu)
echo "$out"
echo "$out" | grep -q '^>>> PASS$'
